// File: verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and pc width
`define XLEN 32

// instruction word width
`define INST_W 32

// register file address width, x0..x31
`define REG_ADDR_W 5

// sequential pc increment
`define PC_STEP 4

`endif

// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes, inst[6:0]
	localparam logic [6:0] opc_op_imm   = 7'b0010011;
	localparam logic [6:0] opc_op       = 7'b0110011;
	localparam logic [6:0] opc_branch   = 7'b1100011;
	localparam logic [6:0] opc_jal      = 7'b1101111;
	localparam logic [6:0] opc_jalr     = 7'b1100111;
	localparam logic [6:0] opc_lui      = 7'b0110111;
	localparam logic [6:0] opc_auipc    = 7'b0010111;
	localparam logic [6:0] opc_misc_mem = 7'b0001111;

	localparam logic [2:0] f3_add_sub = 3'b000; // also addi
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_sr      = 3'b101; // srl/sra by funct7
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_mulhu  = 3'b011;

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [2:0] f3_jalr  = 3'b000;
	localparam logic [2:0] f3_fence = 3'b000;

	localparam logic [6:0] f7_base   = 7'b0000000;
	localparam logic [6:0] f7_alt    = 7'b0100000; // sub, sra
	localparam logic [6:0] f7_muldiv = 7'b0000001;

endpackage

// File: verilog/rv_exec_pkg.sv
`include "rv_macros.svh"

package rv_exec_pkg;

	typedef enum logic [3:0] {
		cls_alu,
		cls_mul,
		cls_branch,
		cls_jal,
		cls_jalr,
		cls_lui,
		cls_auipc,
		cls_pc_only, // fence, pc+4 only
		cls_illegal
	} op_class_e;

	typedef enum logic [4:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and,
		alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
		alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
	} alu_op_e;

	typedef struct packed {
		op_class_e op_class;
		alu_op_e alu_op;
		logic use_imm; // second operand is imm, not rs2
		logic [`XLEN-1:0] imm;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1;
		logic [`XLEN-1:0] rs2;
	} dec_op_t;

endpackage

// File: verilog/rv_stage_if.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

// decode -> execute
interface dec_stage_if;
	logic valid; // one cycle per request
	rv_exec_pkg::dec_op_t op;

	modport source (
		output valid,
		output op
	);

	modport sink (
		input valid,
		input op
	);
endinterface

// execute -> result
interface exe_stage_if;
	logic valid; // one cycle per request
	logic we;
	logic [`REG_ADDR_W-1:0] waddr;
	logic [`XLEN-1:0] wdata;
	logic [`XLEN-1:0] pc_n;
	logic err; // illegal instruction

	modport source (
		output valid,
		output we,
		output waddr,
		output wdata,
		output pc_n,
		output err
	);

	modport sink (
		input valid,
		input we,
		input waddr,
		input wdata,
		input pc_n,
		input err
	);
endinterface

// File: verilog/rv_decode.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_decode (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	input logic [`INST_W-1:0] inst_i,
	input logic [`XLEN-1:0] pc_i,
	input logic [`XLEN-1:0] rs1_data_i,
	input logic [`XLEN-1:0] rs2_data_i,
	dec_stage_if.source dec_o
);

	logic req_q; // req_i at the previous edge
	logic req_rise;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	rv_exec_pkg::dec_op_t op_c;

	assign req_rise = req_i & ~req_q;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'h000}; // already in place, no extra shift
	assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		op_c.op_class = rv_exec_pkg::cls_illegal; // anything not matched below
		op_c.alu_op = rv_exec_pkg::alu_add;
		op_c.use_imm = 1'b0;
		op_c.imm = imm_i;
		op_c.rd = inst_i[11:7];
		op_c.pc = pc_i;
		op_c.rs1 = rs1_data_i;
		op_c.rs2 = rs2_data_i;
		case (opcode)
			rv_isa_pkg::opc_op_imm: begin
				op_c.op_class = rv_exec_pkg::cls_alu;
				op_c.use_imm = 1'b1;
				case (funct3)
					rv_isa_pkg::f3_add_sub: op_c.alu_op = rv_exec_pkg::alu_add;
					rv_isa_pkg::f3_slt: op_c.alu_op = rv_exec_pkg::alu_slt;
					rv_isa_pkg::f3_sltu: op_c.alu_op = rv_exec_pkg::alu_sltu;
					rv_isa_pkg::f3_xor: op_c.alu_op = rv_exec_pkg::alu_xor;
					rv_isa_pkg::f3_or: op_c.alu_op = rv_exec_pkg::alu_or;
					rv_isa_pkg::f3_and: op_c.alu_op = rv_exec_pkg::alu_and;
					rv_isa_pkg::f3_sll: begin
						op_c.alu_op = rv_exec_pkg::alu_sll;
						if (funct7 != rv_isa_pkg::f7_base)
							op_c.op_class = rv_exec_pkg::cls_illegal;
					end
					default: begin // srli / srai
						if (funct7 == rv_isa_pkg::f7_base)
							op_c.alu_op = rv_exec_pkg::alu_srl;
						else if (funct7 == rv_isa_pkg::f7_alt)
							op_c.alu_op = rv_exec_pkg::alu_sra;
						else
							op_c.op_class = rv_exec_pkg::cls_illegal;
					end
				endcase
			end
			rv_isa_pkg::opc_op: begin
				case (funct7)
					rv_isa_pkg::f7_base: begin
						op_c.op_class = rv_exec_pkg::cls_alu;
						case (funct3)
							rv_isa_pkg::f3_add_sub: op_c.alu_op = rv_exec_pkg::alu_add;
							rv_isa_pkg::f3_sll: op_c.alu_op = rv_exec_pkg::alu_sll;
							rv_isa_pkg::f3_slt: op_c.alu_op = rv_exec_pkg::alu_slt;
							rv_isa_pkg::f3_sltu: op_c.alu_op = rv_exec_pkg::alu_sltu;
							rv_isa_pkg::f3_xor: op_c.alu_op = rv_exec_pkg::alu_xor;
							rv_isa_pkg::f3_sr: op_c.alu_op = rv_exec_pkg::alu_srl;
							rv_isa_pkg::f3_or: op_c.alu_op = rv_exec_pkg::alu_or;
							default: op_c.alu_op = rv_exec_pkg::alu_and;
						endcase
					end
					rv_isa_pkg::f7_alt: begin
						op_c.op_class = rv_exec_pkg::cls_alu;
						if (funct3 == rv_isa_pkg::f3_add_sub)
							op_c.alu_op = rv_exec_pkg::alu_sub;
						else if (funct3 == rv_isa_pkg::f3_sr)
							op_c.alu_op = rv_exec_pkg::alu_sra;
						else
							op_c.op_class = rv_exec_pkg::cls_illegal;
					end
					rv_isa_pkg::f7_muldiv: begin
						op_c.op_class = rv_exec_pkg::cls_mul;
						case (funct3)
							rv_isa_pkg::f3_mul: op_c.alu_op = rv_exec_pkg::alu_mul;
							rv_isa_pkg::f3_mulh: op_c.alu_op = rv_exec_pkg::alu_mulh;
							rv_isa_pkg::f3_mulhsu: op_c.alu_op = rv_exec_pkg::alu_mulhsu;
							rv_isa_pkg::f3_mulhu: op_c.alu_op = rv_exec_pkg::alu_mulhu;
							default: op_c.op_class = rv_exec_pkg::cls_illegal; // no divider
						endcase
					end
					default: op_c.op_class = rv_exec_pkg::cls_illegal;
				endcase
			end
			rv_isa_pkg::opc_branch: begin
				op_c.op_class = rv_exec_pkg::cls_branch;
				op_c.imm = imm_b;
				case (funct3)
					rv_isa_pkg::f3_beq: op_c.alu_op = rv_exec_pkg::alu_beq;
					rv_isa_pkg::f3_bne: op_c.alu_op = rv_exec_pkg::alu_bne;
					rv_isa_pkg::f3_blt: op_c.alu_op = rv_exec_pkg::alu_blt;
					rv_isa_pkg::f3_bge: op_c.alu_op = rv_exec_pkg::alu_bge;
					rv_isa_pkg::f3_bltu: op_c.alu_op = rv_exec_pkg::alu_bltu;
					rv_isa_pkg::f3_bgeu: op_c.alu_op = rv_exec_pkg::alu_bgeu;
					default: op_c.op_class = rv_exec_pkg::cls_illegal;
				endcase
			end
			rv_isa_pkg::opc_jal: begin
				op_c.op_class = rv_exec_pkg::cls_jal;
				op_c.imm = imm_j;
			end
			rv_isa_pkg::opc_jalr: begin
				if (funct3 == rv_isa_pkg::f3_jalr)
					op_c.op_class = rv_exec_pkg::cls_jalr;
			end
			rv_isa_pkg::opc_lui: begin
				op_c.op_class = rv_exec_pkg::cls_lui;
				op_c.imm = imm_u;
			end
			rv_isa_pkg::opc_auipc: begin
				op_c.op_class = rv_exec_pkg::cls_auipc;
				op_c.imm = imm_u;
			end
			rv_isa_pkg::opc_misc_mem: begin
				if (funct3 == rv_isa_pkg::f3_fence)
					op_c.op_class = rv_exec_pkg::cls_pc_only;
			end
			default: op_c.op_class = rv_exec_pkg::cls_illegal; // includes ecall/ebreak/wfi
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q <= 1'b0;
			dec_o.valid <= 1'b0;
		end else begin
			req_q <= req_i;
			dec_o.valid <= req_rise; // single pulse per request
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_rise)
			dec_o.op <= op_c;
	end

	// a full four-phase cycle takes at least five edges between rises
	a_req_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
		req_rise |=> !req_rise [*4]);

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_execute (
	input logic clk_i,
	input logic rst_i,
	dec_stage_if.sink dec_i,
	exe_stage_if.source exe_o
);

	rv_exec_pkg::dec_op_t op;
	logic [`XLEN-1:0] opb; // rs2 or immediate
	logic [`XLEN-1:0] add1_in1, add1_in2, add1_res; // result adder
	logic add1_cin;
	logic [`XLEN-1:0] add2_in1, add2_in2, add2_res; // next pc adder
	logic lt_s, lt_u, eq;
	logic [4:0] shamt;
	logic signed [32:0] mul_in1, mul_in2;
	logic signed [65:0] mul_res;
	logic taken;
	logic we_c, err_c;
	logic [`XLEN-1:0] wdata_c, pc_n_c;

	assign op = dec_i.op;
	assign opb = op.use_imm ? op.imm : op.rs2;
	assign add1_res = add1_in1 + add1_in2 + {{(`XLEN-1){1'b0}}, add1_cin};
	assign add2_res = add2_in1 + add2_in2;
	assign lt_s = $signed(op.rs1) < $signed(opb);
	assign lt_u = op.rs1 < opb;
	assign eq = (op.rs1 == opb);
	assign shamt = opb[4:0];
	assign mul_res = mul_in1 * mul_in2;

	always_comb begin
		case (op.alu_op)
			rv_exec_pkg::alu_beq: taken = eq;
			rv_exec_pkg::alu_bne: taken = ~eq;
			rv_exec_pkg::alu_blt: taken = lt_s;
			rv_exec_pkg::alu_bge: taken = ~lt_s;
			rv_exec_pkg::alu_bltu: taken = lt_u;
			rv_exec_pkg::alu_bgeu: taken = ~lt_u;
			default: taken = 1'b0;
		endcase
	end

	// operand steering for the shared adders and the multiplier
	always_comb begin
		add1_in1 = op.rs1;
		add1_in2 = opb;
		add1_cin = 1'b0;
		add2_in1 = op.pc;
		add2_in2 = `PC_STEP;
		mul_in1 = {op.rs1[`XLEN-1], op.rs1};
		mul_in2 = {op.rs2[`XLEN-1], op.rs2};
		case (op.op_class)
			rv_exec_pkg::cls_alu: begin
				if (op.alu_op == rv_exec_pkg::alu_sub) begin
					add1_in2 = ~opb; // two's complement subtract
					add1_cin = 1'b1;
				end
			end
			rv_exec_pkg::cls_mul: begin
				if (op.alu_op == rv_exec_pkg::alu_mulhsu) begin
					mul_in2 = {1'b0, op.rs2};
				end else if (op.alu_op == rv_exec_pkg::alu_mulhu) begin
					mul_in1 = {1'b0, op.rs1};
					mul_in2 = {1'b0, op.rs2};
				end
			end
			rv_exec_pkg::cls_branch: begin
				if (taken)
					add2_in2 = op.imm;
			end
			rv_exec_pkg::cls_jal, rv_exec_pkg::cls_jalr: begin
				add1_in1 = op.pc; // link address
				add1_in2 = `PC_STEP;
				add2_in2 = op.imm;
				if (op.op_class == rv_exec_pkg::cls_jalr)
					add2_in1 = op.rs1;
			end
			rv_exec_pkg::cls_auipc: begin
				add1_in1 = op.pc;
				add1_in2 = op.imm;
			end
			default: ;
		endcase
	end

	always_comb begin
		we_c = 1'b0;
		err_c = 1'b0;
		wdata_c = add1_res;
		pc_n_c = add2_res;
		case (op.op_class)
			rv_exec_pkg::cls_alu: begin
				we_c = 1'b1;
				case (op.alu_op)
					rv_exec_pkg::alu_sll: wdata_c = op.rs1 << shamt;
					rv_exec_pkg::alu_srl: wdata_c = op.rs1 >> shamt;
					rv_exec_pkg::alu_sra: wdata_c = $signed(op.rs1) >>> shamt;
					rv_exec_pkg::alu_slt: wdata_c = {{(`XLEN-1){1'b0}}, lt_s};
					rv_exec_pkg::alu_sltu: wdata_c = {{(`XLEN-1){1'b0}}, lt_u};
					rv_exec_pkg::alu_xor: wdata_c = op.rs1 ^ opb;
					rv_exec_pkg::alu_or: wdata_c = op.rs1 | opb;
					rv_exec_pkg::alu_and: wdata_c = op.rs1 & opb;
					default: wdata_c = add1_res; // add, sub
				endcase
			end
			rv_exec_pkg::cls_mul: begin
				we_c = 1'b1;
				if (op.alu_op == rv_exec_pkg::alu_mul)
					wdata_c = mul_res[31:0];
				else
					wdata_c = mul_res[63:32];
			end
			rv_exec_pkg::cls_jal, rv_exec_pkg::cls_jalr, rv_exec_pkg::cls_auipc: we_c = 1'b1;
			rv_exec_pkg::cls_lui: begin
				we_c = 1'b1;
				wdata_c = op.imm;
			end
			rv_exec_pkg::cls_illegal: begin
				err_c = 1'b1;
				pc_n_c = op.pc; // stay on the faulting instruction
			end
			default: ; // branch, fence
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			exe_o.valid <= 1'b0;
		else
			exe_o.valid <= dec_i.valid;
	end

	always_ff @(posedge clk_i) begin
		if (dec_i.valid) begin
			exe_o.we <= we_c;
			exe_o.waddr <= op.rd;
			exe_o.wdata <= wdata_c;
			exe_o.pc_n <= pc_n_c;
			exe_o.err <= err_c;
		end
	end

	// decode pulses once per request since there is no back-pressure
	a_dec_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		dec_i.valid |=> !dec_i.valid);

endmodule

// File: verilog/rv_result.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_result (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	exe_stage_if.sink exe_i,
	output logic ack_o,
	output logic reg_we_o,
	output logic [`REG_ADDR_W-1:0] reg_waddr_o,
	output logic [`XLEN-1:0] reg_wdata_o,
	output logic [`XLEN-1:0] pc_n_o,
	output logic inst_err_o
);

	logic cap_q; // outputs loaded last edge, ack follows

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cap_q <= 1'b0;
			ack_o <= 1'b0;
			reg_we_o <= 1'b0;
			inst_err_o <= 1'b0;
		end else begin
			cap_q <= exe_i.valid;
			if (exe_i.valid) begin
				reg_we_o <= exe_i.we;
				inst_err_o <= exe_i.err;
			end
			if (cap_q)
				ack_o <= 1'b1;
			else if (!req_i)
				ack_o <= 1'b0; // four-phase release
		end
	end

	// results hold after ack drops
	always_ff @(posedge clk_i) begin
		if (exe_i.valid) begin
			reg_waddr_o <= exe_i.waddr;
			reg_wdata_o <= exe_i.wdata;
			pc_n_o <= exe_i.pc_n;
		end
	end

	// requester must wait for ack before releasing req
	a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(req_i) |-> ack_o);

	// only one request in flight
	a_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
		exe_i.valid |-> !ack_o);

endmodule

// File: verilog/rv_idex_top.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_idex_top (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	input logic [`INST_W-1:0] inst_i,
	input logic [`XLEN-1:0] pc_i,
	input logic [`XLEN-1:0] rs1_data_i,
	input logic [`XLEN-1:0] rs2_data_i,
	output logic ack_o,
	output logic reg_we_o,
	output logic [`REG_ADDR_W-1:0] reg_waddr_o,
	output logic [`XLEN-1:0] reg_wdata_o,
	output logic [`XLEN-1:0] pc_n_o,
	output logic inst_err_o
);

	dec_stage_if dec_if ();
	exe_stage_if exe_if ();

	rv_decode rv_decode_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req_i),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.dec_o(dec_if.source)
	);

	rv_execute rv_execute_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dec_i(dec_if.sink),
		.exe_o(exe_if.source)
	);

	rv_result rv_result_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req_i),
		.exe_i(exe_if.sink),
		.ack_o(ack_o),
		.reg_we_o(reg_we_o),
		.reg_waddr_o(reg_waddr_o),
		.reg_wdata_o(reg_wdata_o),
		.pc_n_o(pc_n_o),
		.inst_err_o(inst_err_o)
	);

endmodule

// File: verification/tb_vectors.svh
function automatic void load_vectors();
	// name, inst, pc, rs1, rs2 | expected we, rd, wdata, pc_n, err
	add_vector("addi", enc_i(-5, 0, 5, 'h13), pc_base, 100, 0, 1, 5, 'h5f, pc_seq, 0);
	add_vector("slti_neg", enc_i(-1, 2, 6, 'h13), pc_base, 'hfffffffe, 0, 1, 6, 1, pc_seq, 0);
	add_vector("slti_false", enc_i(-8, 2, 6, 'h13), pc_base, 3, 0, 1, 6, 0, pc_seq, 0);
	add_vector("sltiu_neg", enc_i(-1, 3, 7, 'h13), pc_base, 5, 0, 1, 7, 1, pc_seq, 0);
	add_vector("sltiu_eq", enc_i(-1, 3, 7, 'h13), pc_base, 'hffffffff, 0, 1, 7, 0, pc_seq, 0);
	add_vector("xori", enc_i('hff0, 4, 8, 'h13), pc_base, 'h12345678, 0,
		1, 8, 'hedcba988, pc_seq, 0);
	add_vector("ori", enc_i('h0f0, 6, 9, 'h13), pc_base, 'h12340005, 0,
		1, 9, 'h123400f5, pc_seq, 0);
	add_vector("andi", enc_i('h7f0, 7, 10, 'h13), pc_base, 'habcdef12, 0,
		1, 10, 'h710, pc_seq, 0);
	add_vector("slli", enc_i(7, 1, 11, 'h13), pc_base, 3, 0, 1, 11, 'h180, pc_seq, 0);
	add_vector("srli", enc_i(12, 5, 12, 'h13), pc_base, 'h80001000, 0,
		1, 12, 'h00080001, pc_seq, 0);
	add_vector("srai", enc_i('h410, 5, 13, 'h13), pc_base, 'h80001000, 0,
		1, 13, 'hffff8000, pc_seq, 0);
	add_vector("add", enc_r(0, 0, 14), pc_base, 'h7fffffff, 1, 1, 14, 'h80000000, pc_seq, 0);
	add_vector("sub", enc_r('h20, 0, 15), pc_base, 5, 7, 1, 15, 'hfffffffe, pc_seq, 0);
	add_vector("sll", enc_r(0, 1, 16), pc_base, 1, 'h23, 1, 16, 8, pc_seq, 0); // only rs2[4:0]
	add_vector("slt", enc_r(0, 2, 17), pc_base, 'h80000000, 1, 1, 17, 1, pc_seq, 0);
	add_vector("sltu", enc_r(0, 3, 18), pc_base, 'h80000000, 1, 1, 18, 0, pc_seq, 0);
	add_vector("xor", enc_r(0, 4, 19), pc_base, 'hff00ff00, 'h0ff00ff0,
		1, 19, 'hf0f0f0f0, pc_seq, 0);
	add_vector("srl", enc_r(0, 5, 20), pc_base, 'hf0000000, 4, 1, 20, 'h0f000000, pc_seq, 0);
	add_vector("sra", enc_r('h20, 5, 21), pc_base, 'hf0000000, 4, 1, 21, 'hff000000, pc_seq, 0);
	add_vector("or", enc_r(0, 6, 22), pc_base, 'h00ff0000, 'hff, 1, 22, 'h00ff00ff, pc_seq, 0);
	add_vector("and", enc_r(0, 7, 23), pc_base, 'hff00ff00, 'h0ff00ff0,
		1, 23, 'h0f000f00, pc_seq, 0);
	add_vector("mul_min_neg1", enc_r(1, 0, 24), pc_base, 'h80000000, 'hffffffff,
		1, 24, 'h80000000, pc_seq, 0);
	add_vector("mul_neg1_sq", enc_r(1, 0, 24), pc_base, 'hffffffff, 'hffffffff,
		1, 24, 1, pc_seq, 0);
	add_vector("mulh_min_sq", enc_r(1, 1, 25), pc_base, 'h80000000, 'h80000000,
		1, 25, 'h40000000, pc_seq, 0);
	add_vector("mulh_min_neg1", enc_r(1, 1, 25), pc_base, 'h80000000, 'hffffffff,
		1, 25, 0, pc_seq, 0);
	add_vector("mulhsu_neg1", enc_r(1, 2, 26), pc_base, 'hffffffff, 'hffffffff,
		1, 26, 'hffffffff, pc_seq, 0);
	add_vector("mulhsu_max", enc_r(1, 2, 26), pc_base, 'h7fffffff, 'hffffffff,
		1, 26, 'h7ffffffe, pc_seq, 0);
	add_vector("mulhsu_min", enc_r(1, 2, 26), pc_base, 'h80000000, 'h80000000,
		1, 26, 'hc0000000, pc_seq, 0);
	add_vector("mulhu_max", enc_r(1, 3, 27), pc_base, 'hffffffff, 'hffffffff,
		1, 27, 'hfffffffe, pc_seq, 0);
	add_vector("beq_t", enc_b(-8, 0), pc_base, 'h55, 'h55, 0, 0, 0, 'h00000ff8, 0);
	add_vector("beq_nt", enc_b(-8, 0), pc_base, 'h55, 'h56, 0, 0, 0, pc_seq, 0);
	add_vector("bne_t", enc_b(16, 1), pc_base, 1, 2, 0, 0, 0, 'h1010, 0);
	add_vector("bne_nt", enc_b(16, 1), pc_base, 3, 3, 0, 0, 0, pc_seq, 0);
	add_vector("blt_t", enc_b(16, 4), pc_base, 'hffffffff, 1, 0, 0, 0, 'h1010, 0);
	add_vector("blt_nt", enc_b(16, 4), pc_base, 1, 'hffffffff, 0, 0, 0, pc_seq, 0);
	add_vector("bge_t", enc_b(16, 5), pc_base, 1, 'hffffffff, 0, 0, 0, 'h1010, 0);
	add_vector("bge_nt", enc_b(16, 5), pc_base, 'hffffffff, 1, 0, 0, 0, pc_seq, 0);
	add_vector("bltu_t", enc_b(16, 6), pc_base, 1, 'hffffffff, 0, 0, 0, 'h1010, 0);
	add_vector("bltu_nt", enc_b(16, 6), pc_base, 'hffffffff, 1, 0, 0, 0, pc_seq, 0);
	add_vector("bgeu_t", enc_b('h800, 7), pc_base, 'hffffffff, 1, 0, 0, 0, 'h1800, 0);
	add_vector("bgeu_nt", enc_b('h800, 7), pc_base, 1, 'hffffffff, 0, 0, 0, pc_seq, 0);
	add_vector("jal_fwd", enc_j('h800, 1), pc_base, 0, 0, 1, 1, pc_seq, 'h1800, 0);
	add_vector("jal_back", enc_j(-16, 1), 'h2000, 0, 0, 1, 1, 'h2004, 'h1ff0, 0);
	add_vector("jalr", enc_i(-4, 0, 1, 'h67), pc_base, 'h4000, 0, 1, 1, pc_seq, 'h3ffc, 0);
	add_vector("lui", enc_u('hdead0, 3, 'h37), pc_base, 0, 0, 1, 3, 'hdead0000, pc_seq, 0);
	add_vector("auipc", enc_u('h12, 4, 'h17), pc_base, 0, 0, 1, 4, 'h00013000, pc_seq, 0);
	add_vector("fence", 'h0ff0000f, pc_base, 0, 0, 0, 0, 0, pc_seq, 0);
	add_vector("bad_opcode", 'h0000007b, pc_base, 0, 0, 0, 0, 0, pc_base, 1);
	add_vector("bad_funct7", enc_r('h40, 0, 5), pc_base, 1, 2, 0, 0, 0, pc_base, 1);
	add_vector("ecall", 'h00000073, pc_base, 0, 0, 0, 0, 0, pc_base, 1);
endfunction

// File: verification/tb_rv_idex.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module tb_rv_idex;

	typedef struct packed {
		logic [`INST_W-1:0] inst;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rs1;
		logic [`XLEN-1:0] rs2;
		logic we;
		logic [`REG_ADDR_W-1:0] waddr;
		logic [`XLEN-1:0] wdata;
		logic [`XLEN-1:0] pc_n;
		logic err;
	} vector_t;

	localparam logic [31:0] pc_base = 32'h0000_1000;
	localparam logic [31:0] pc_seq = 32'h0000_1004;

	logic clk_i;
	logic rst_i;
	logic req_i;
	logic [`INST_W-1:0] inst_i;
	logic [`XLEN-1:0] pc_i;
	logic [`XLEN-1:0] rs1_data_i;
	logic [`XLEN-1:0] rs2_data_i;
	logic ack_o;
	logic reg_we_o;
	logic [`REG_ADDR_W-1:0] reg_waddr_o;
	logic [`XLEN-1:0] reg_wdata_o;
	logic [`XLEN-1:0] pc_n_o;
	logic inst_err_o;

	vector_t vectors[$];
	string names[$];
	int unsigned cycle_cnt;
	int unsigned cycle_limit;

	rv_idex_top rv_idex_top_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req_i),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.ack_o(ack_o),
		.reg_we_o(reg_we_o),
		.reg_waddr_o(reg_waddr_o),
		.reg_wdata_o(reg_wdata_o),
		.pc_n_o(pc_n_o),
		.inst_err_o(inst_err_o)
	);

	always #20 clk_i = ~clk_i; // 40 ns period

	always @(posedge clk_i) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the run exceeded %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$fatal(1, "run aborted");
		end
	end

	// rs1 field = x1, register numbers do not reach the DUT
	function automatic logic [31:0] enc_i(input logic [31:0] imm, f3, rd, opc);
		enc_i = {imm[11:0], 5'd1, f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_r(input logic [31:0] f7, f3, rd);
		enc_r = {f7[6:0], 5'd2, 5'd1, f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, f3);
		enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_u(input logic [31:0] imm, rd, opc);
		enc_u = {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic void add_vector(input string name, input logic [31:0] inst, pc, rs1, rs2,
			input logic [31:0] we, waddr, wdata, pc_n, err);
		vector_t v;
		v.inst = inst;
		v.pc = pc;
		v.rs1 = rs1;
		v.rs2 = rs2;
		v.we = we[0];
		v.waddr = waddr[4:0];
		v.wdata = wdata;
		v.pc_n = pc_n;
		v.err = err[0];
		vectors.push_back(v);
		names.push_back(name);
	endfunction

	`include "tb_vectors.svh"

	task automatic check_value(input string test, input string field,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test, field, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch in %s", test);
		end
	endtask

	task automatic run_vector(input int idx);
		vector_t v;
		int latency;
		v = vectors[idx];
		@(negedge clk_i);
		inst_i = v.inst;
		pc_i = v.pc;
		rs1_data_i = v.rs1;
		rs2_data_i = v.rs2;
		req_i = 1'b1;
		latency = 0;
		do begin
			@(negedge clk_i);
			latency++;
		end while (!ack_o);
		// rise seen at the next edge, ack three edges later
		check_value(names[idx], "ack latency", 4, latency);
		check_value(names[idx], "we", 32'(v.we), 32'(reg_we_o));
		check_value(names[idx], "err", 32'(v.err), 32'(inst_err_o));
		check_value(names[idx], "pc_n", v.pc_n, pc_n_o);
		if (v.we) begin
			check_value(names[idx], "waddr", 32'(v.waddr), 32'(reg_waddr_o));
			check_value(names[idx], "wdata", v.wdata, reg_wdata_o);
		end
		req_i = 1'b0;
		latency = 0;
		do begin
			@(negedge clk_i);
			latency++;
		end while (ack_o);
		check_value(names[idx], "ack release", 1, latency);
		repeat ($urandom % 4) @(negedge clk_i); // idle gap
	endtask

	initial begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		req_i = 1'b0;
		inst_i = '0;
		pc_i = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		cycle_cnt = 0;
		void'($urandom(32'hd5f2));
		load_vectors();
		cycle_limit = vectors.size() * 16 + 20;
		repeat (8) @(negedge clk_i);
		rst_i = 1'b0;
		check_value("reset", "ack", 0, 32'(ack_o));
		check_value("reset", "we", 0, 32'(reg_we_o));
		check_value("reset", "err", 0, 32'(inst_err_o));
		for (int i = 0; i < vectors.size(); i++)
			run_vector(i);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: flist.f
+incdir+verilog
+incdir+verification
verilog/rv_isa_pkg.sv
verilog/rv_exec_pkg.sv
verilog/rv_stage_if.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_idex_top.sv
verification/tb_rv_idex.sv

// File: Makefile
TOP = tb_rv_idex

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

# the run fails unless the pass line appears in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
